//--- Makefile
# Verilator build and run for the debug observation subsystem

VERILATOR ?= verilator
TOP       ?= gat_debug_tb
FILELIST  ?= gat_debug.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Regression passed

.PHONY: help test clean

help:
	@echo "available targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
	  echo "test target: PASS"; \
	else \
	  echo "test target: FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- gat_debug.f
src/gat_debug_pkg.sv
src/stage_flag_monitor.sv
src/trace_fifo.sv
src/debug_readout.sv
src/gat_debug_top.sv
verification/gat_debug_asserts.sv
verification/gat_debug_tb.sv

//--- src/debug_readout.sv
`timescale 1ns/100ps

module debug_readout (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  pop_i,
  input  logic [gat_debug_pkg::FLAG_W-1:0]      flags_i,
  input  logic [gat_debug_pkg::TRACE_CNT_W-1:0] count_i,
  input  logic                                  overflow_i,
  input  logic [gat_debug_pkg::TRACE_W-1:0]     head_i,
  output logic                                  trace_pop_o,
  output logic [gat_debug_pkg::DEBUG_W-1:0]     status_o,
  output logic [gat_debug_pkg::DEBUG_W-1:0]     trace_word_o,
  output logic                                  empty_o
);

  logic                                  empty;
  logic                                  accept;
  logic                                  trace_pop_q;
  logic [gat_debug_pkg::DEBUG_W-1:0]     trace_word_q;

  assign empty = (count_i == '0);

  // skip the cycle after an accepted pop, the queue count is still stale then
  assign accept = pop_i && !empty && !trace_pop_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_pop_q <= 1'b0;
    end else begin
      trace_pop_q <= accept;
    end
  end

  // head is captured now and removed from the queue one edge later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_word_q <= '0;
    end else if (accept) begin
      trace_word_q <= head_i;
    end
  end

  // status word: flags, overflow, fill count, rest zero
  assign status_o = {
    {(gat_debug_pkg::DEBUG_W - gat_debug_pkg::FLAG_W - 1 - gat_debug_pkg::TRACE_CNT_W){1'b0}},
    count_i,
    overflow_i,
    flags_i
  };

  assign trace_pop_o  = trace_pop_q;
  assign trace_word_o = trace_word_q;
  assign empty_o      = empty;

endmodule

//--- src/gat_debug_pkg.sv
package gat_debug_pkg;

  // watched stages, vector index order is spmm, dmvm, sm, aggr from the top
  localparam int NUM_STAGES = 4;
  localparam int STAGE_SPMM = 3;
  localparam int STAGE_SM   = 1;

  // sticky flags: vld/rdy pairs plus feature write seen and out-of-range write
  localparam int FLAG_W = 2 * NUM_STAGES + 2;

  localparam int SPPE_LANES   = 16;
  localparam int SPPE_W       = 12;
  localparam int CAPTURE_LANE = 2;

  localparam int WH_ADDR_W   = 14;
  localparam int FEAT_ADDR_W = 16;

  localparam logic [FEAT_ADDR_W-1:0] FEAT_ADDR_LIMIT = 16'd43328;
  localparam logic [WH_ADDR_W-1:0]   CAPTURE_ADDR_A  = 14'd10;
  localparam logic [WH_ADDR_W-1:0]   CAPTURE_ADDR_B  = 14'd20;

  localparam int DEBUG_W = 32;

  // trace entry is {slot, stamp, sample}
  localparam int TRACE_W   = 32;
  localparam int STAMP_W   = 19;
  localparam int STAMP_LSB = SPPE_W;
  localparam int SLOT_BIT  = TRACE_W - 1;

  localparam int TRACE_DEPTH  = 8;
  localparam int TRACE_PTR_W  = $clog2(TRACE_DEPTH);
  localparam int TRACE_CNT_W  = 4;
  localparam logic [TRACE_CNT_W-1:0] TRACE_FULL_CNT = TRACE_CNT_W'(TRACE_DEPTH);

endpackage

//--- src/gat_debug_top.sv
`timescale 1ns/100ps

module gat_debug_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [gat_debug_pkg::NUM_STAGES-1:0]  stage_vld_i,
  input  logic [gat_debug_pkg::NUM_STAGES-1:0]  stage_rdy_i,
  input  logic                                  feat_ena_i,
  input  logic [gat_debug_pkg::FEAT_ADDR_W-1:0] feat_addr_i,
  input  logic [gat_debug_pkg::WH_ADDR_W-1:0]   wh_addr_i,
  input  logic [gat_debug_pkg::SPPE_LANES-1:0]
               [gat_debug_pkg::SPPE_W-1:0]      sppe_i,
  input  logic                                  clear_i,
  input  logic                                  pop_i,
  output logic [gat_debug_pkg::DEBUG_W-1:0]     debug_1_o,
  output logic [gat_debug_pkg::DEBUG_W-1:0]     debug_2_o,
  output logic [gat_debug_pkg::DEBUG_W-1:0]     debug_3_o,
  output logic                                  trace_empty_o
);

  logic [gat_debug_pkg::FLAG_W-1:0]      flags;
  logic                                  trace_push;
  logic [gat_debug_pkg::TRACE_W-1:0]     trace_entry;
  logic [gat_debug_pkg::TRACE_W-1:0]     trace_head;
  logic [gat_debug_pkg::TRACE_CNT_W-1:0] trace_count;
  logic                                  trace_overflow;
  logic                                  trace_pop;

  stage_flag_monitor monitor_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .clear_i       (clear_i),
    .stage_vld_i   (stage_vld_i),
    .stage_rdy_i   (stage_rdy_i),
    .feat_ena_i    (feat_ena_i),
    .feat_addr_i   (feat_addr_i),
    .wh_addr_i     (wh_addr_i),
    .sppe_i        (sppe_i),
    .flags_o       (flags),
    .sm_count_o    (debug_2_o),
    .trace_push_o  (trace_push),
    .trace_entry_o (trace_entry)
  );

  trace_fifo fifo_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_i     (trace_push),
    .entry_i    (trace_entry),
    .pop_i      (trace_pop),
    .head_o     (trace_head),
    .count_o    (trace_count),
    .overflow_o (trace_overflow)
  );

  debug_readout readout_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .pop_i        (pop_i),
    .flags_i      (flags),
    .count_i      (trace_count),
    .overflow_i   (trace_overflow),
    .head_i       (trace_head),
    .trace_pop_o  (trace_pop),
    .status_o     (debug_1_o),
    .trace_word_o (debug_3_o),
    .empty_o      (trace_empty_o)
  );

endmodule

//--- src/stage_flag_monitor.sv
`timescale 1ns/100ps

module stage_flag_monitor (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      clear_i,
  input  logic [gat_debug_pkg::NUM_STAGES-1:0]      stage_vld_i,
  input  logic [gat_debug_pkg::NUM_STAGES-1:0]      stage_rdy_i,
  input  logic                                      feat_ena_i,
  input  logic [gat_debug_pkg::FEAT_ADDR_W-1:0]     feat_addr_i,
  input  logic [gat_debug_pkg::WH_ADDR_W-1:0]       wh_addr_i,
  input  logic [gat_debug_pkg::SPPE_LANES-1:0]
               [gat_debug_pkg::SPPE_W-1:0]          sppe_i,
  output logic [gat_debug_pkg::FLAG_W-1:0]          flags_o,
  output logic [gat_debug_pkg::DEBUG_W-1:0]         sm_count_o,
  output logic                                      trace_push_o,
  output logic [gat_debug_pkg::TRACE_W-1:0]         trace_entry_o
);

  logic [2*gat_debug_pkg::NUM_STAGES-1:0] stage_hit;
  logic [gat_debug_pkg::FLAG_W-1:0]       flag_hit;
  logic [gat_debug_pkg::FLAG_W-1:0]       flag_q;

  logic                                   feat_oor;
  logic                                   sm_vld;
  logic [gat_debug_pkg::DEBUG_W-1:0]      sm_inc;
  logic [gat_debug_pkg::DEBUG_W-1:0]      sm_count_q;

  logic                                   spmm_rdy;
  logic                                   hit_a;
  logic                                   hit_b;
  logic                                   capture;
  logic [gat_debug_pkg::SPPE_W-1:0]       sample;
  logic                                   trace_push_q;
  logic [gat_debug_pkg::TRACE_W-1:0]      trace_entry_q;

  // interleave strobes so each stage owns a vld/rdy pair, spmm on top
  always_comb begin
    for (int s = 0; s < gat_debug_pkg::NUM_STAGES; s++) begin
      stage_hit[2*s+1] = stage_vld_i[s];
      stage_hit[2*s]   = stage_rdy_i[s];
    end
  end

  assign feat_oor = feat_ena_i && (feat_addr_i >= gat_debug_pkg::FEAT_ADDR_LIMIT);
  assign flag_hit = {feat_oor, feat_ena_i, stage_hit};

  // or-hold flags; a strobe in the clear cycle still lands
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flag_q <= '0;
    end else if (clear_i) begin
      flag_q <= flag_hit;
    end else begin
      flag_q <= flag_q | flag_hit;
    end
  end

  // softmax event counter, wraps at 2^32
  assign sm_vld = stage_vld_i[gat_debug_pkg::STAGE_SM];
  assign sm_inc = {{(gat_debug_pkg::DEBUG_W-1){1'b0}}, sm_vld};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_count_q <= '0;
    end else if (clear_i) begin
      sm_count_q <= sm_inc;
    end else begin
      sm_count_q <= sm_count_q + sm_inc;
    end
  end

  // lane capture on a trigger address while spmm is ready
  assign spmm_rdy = stage_rdy_i[gat_debug_pkg::STAGE_SPMM];
  assign hit_a    = (wh_addr_i == gat_debug_pkg::CAPTURE_ADDR_A);
  assign hit_b    = (wh_addr_i == gat_debug_pkg::CAPTURE_ADDR_B);
  assign capture  = spmm_rdy && (hit_a || hit_b);
  assign sample   = sppe_i[gat_debug_pkg::CAPTURE_LANE];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_push_q <= 1'b0;
    end else begin
      trace_push_q <= capture;
    end
  end

  // stamp is the count before this cycle's increment
  always_ff @(posedge clk) begin
    if (capture) begin
      trace_entry_q[gat_debug_pkg::SLOT_BIT] <= hit_b;
      trace_entry_q[gat_debug_pkg::SLOT_BIT-1:gat_debug_pkg::STAMP_LSB] <=
        sm_count_q[gat_debug_pkg::STAMP_W-1:0];
      trace_entry_q[gat_debug_pkg::STAMP_LSB-1:0] <= sample;
    end
  end

  assign flags_o       = flag_q;
  assign sm_count_o    = sm_count_q;
  assign trace_push_o  = trace_push_q;
  assign trace_entry_o = trace_entry_q;

endmodule

//--- src/trace_fifo.sv
`timescale 1ns/100ps

module trace_fifo (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  push_i,
  input  logic [gat_debug_pkg::TRACE_W-1:0]     entry_i,
  input  logic                                  pop_i,
  output logic [gat_debug_pkg::TRACE_W-1:0]     head_o,
  output logic [gat_debug_pkg::TRACE_CNT_W-1:0] count_o,
  output logic                                  overflow_o
);

  logic [gat_debug_pkg::TRACE_W-1:0]     mem_q [gat_debug_pkg::TRACE_DEPTH];
  logic [gat_debug_pkg::TRACE_PTR_W-1:0] wr_ptr_q;
  logic [gat_debug_pkg::TRACE_PTR_W-1:0] rd_ptr_q;
  logic [gat_debug_pkg::TRACE_CNT_W-1:0] count_q;
  logic                                  overflow_q;

  logic full;
  logic empty;
  logic do_push;
  logic do_pop;

  assign full  = (count_q == gat_debug_pkg::TRACE_FULL_CNT);
  assign empty = (count_q == '0);

  // a full queue drops the entry even if a pop arrives in the same cycle
  assign do_push = push_i && !full;
  assign do_pop  = pop_i && !empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  // depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // sticky until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow_q <= 1'b0;
    end else if (push_i && full) begin
      overflow_q <= 1'b1;
    end
  end

  assign head_o     = mem_q[rd_ptr_q];
  assign count_o    = count_q;
  assign overflow_o = overflow_q;

endmodule

//--- verification/gat_debug_asserts.sv
`timescale 1ns/100ps

module gat_debug_asserts (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [gat_debug_pkg::TRACE_CNT_W-1:0] count_i,
  input  logic                                  overflow_i
);

  // fill count never goes past the queue depth
  count_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    count_i <= gat_debug_pkg::TRACE_FULL_CNT
  ) else $error("trace queue count is above the queue depth");

  // overflow holds until reset
  overflow_sticky: assert property (
    @(posedge clk) disable iff (!rst_n)
    $past(overflow_i) |-> overflow_i
  ) else $error("trace queue overflow fell without a reset");

  // one push and one pop per cycle at most
  count_single_step: assert property (
    @(posedge clk) disable iff (!rst_n)
    (count_i == $past(count_i)) ||
    (count_i == $past(count_i) + 1'b1) ||
    (count_i == $past(count_i) - 1'b1)
  ) else $error("trace queue count moved by more than one in a cycle");

endmodule

//--- verification/gat_debug_tb.sv
`timescale 1ns/100ps

module gat_debug_tb;

  typedef enum int {TRIG_RANDOM, TRIG_OFTEN, TRIG_NONE, TRIG_ALWAYS} trig_mode_e;

  logic                                  clk;
  logic                                  rst_n;
  logic [gat_debug_pkg::NUM_STAGES-1:0]  stage_vld_i;
  logic [gat_debug_pkg::NUM_STAGES-1:0]  stage_rdy_i;
  logic                                  feat_ena_i;
  logic [gat_debug_pkg::FEAT_ADDR_W-1:0] feat_addr_i;
  logic [gat_debug_pkg::WH_ADDR_W-1:0]   wh_addr_i;
  logic [gat_debug_pkg::SPPE_LANES-1:0][gat_debug_pkg::SPPE_W-1:0] sppe_i;
  logic                                  clear_i;
  logic                                  pop_i;
  logic [gat_debug_pkg::DEBUG_W-1:0]     debug_1_o;
  logic [gat_debug_pkg::DEBUG_W-1:0]     debug_2_o;
  logic [gat_debug_pkg::DEBUG_W-1:0]     debug_3_o;
  logic                                  trace_empty_o;

  // reference model state
  logic [9:0]  m_flags;
  logic [31:0] m_sm_count;
  logic [31:0] m_queue[$];
  logic        m_ovf;
  logic        m_pend;
  logic [31:0] m_pend_entry;
  logic        m_pop_q;
  logic [31:0] m_word;

  int unsigned drain_timeout = 64;
  int          pops;
  logic [31:0] held_word;

  gat_debug_top dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .stage_vld_i   (stage_vld_i),
    .stage_rdy_i   (stage_rdy_i),
    .feat_ena_i    (feat_ena_i),
    .feat_addr_i   (feat_addr_i),
    .wh_addr_i     (wh_addr_i),
    .sppe_i        (sppe_i),
    .clear_i       (clear_i),
    .pop_i         (pop_i),
    .debug_1_o     (debug_1_o),
    .debug_2_o     (debug_2_o),
    .debug_3_o     (debug_3_o),
    .trace_empty_o (trace_empty_o)
  );

  bind trace_fifo gat_debug_asserts fifo_asserts_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .count_i    (count_o),
    .overflow_i (overflow_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    stop_with_failure($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  initial begin
    #100000;
    stop_with_failure("simulation ran past its time limit");
  end

  function automatic logic [gat_debug_pkg::NUM_STAGES-1:0] sparse_bits();
    logic [gat_debug_pkg::NUM_STAGES-1:0] bits;
    for (int i = 0; i < gat_debug_pkg::NUM_STAGES; i++) begin
      bits[i] = ($urandom_range(7) == 0);
    end
    return bits;
  endfunction

  function automatic logic [gat_debug_pkg::WH_ADDR_W-1:0] trigger_biased_addr();
    int unsigned pick;
    pick = $urandom_range(2);
    if (pick == 0) begin
      return gat_debug_pkg::CAPTURE_ADDR_A;
    end else if (pick == 1) begin
      return gat_debug_pkg::CAPTURE_ADDR_B;
    end else begin
      return 14'($urandom);
    end
  endfunction

  // advance the model by one edge using the inputs the DUT samples at that edge
  function automatic void update_model();
    logic [9:0]  hit;
    logic        oor;
    logic        cap;
    logic        accept;
    logic        push_ok;
    logic        pop_ok;
    int          size;
    size    = m_queue.size();
    accept  = pop_i && (size != 0) && !m_pop_q;
    push_ok = m_pend && (size < gat_debug_pkg::TRACE_DEPTH);
    pop_ok  = m_pop_q && (size != 0);
    if (m_pend && (size == gat_debug_pkg::TRACE_DEPTH)) begin
      m_ovf = 1'b1;
    end
    if (accept) begin
      m_word = m_queue[0];
    end
    if (pop_ok) begin
      m_queue.delete(0);
    end
    if (push_ok) begin
      m_queue.push_back(m_pend_entry);
    end
    m_pop_q = accept;

    // spmm is the top bit of the strobe vectors and sm is bit 1
    cap = stage_rdy_i[3] && ((wh_addr_i == gat_debug_pkg::CAPTURE_ADDR_A) ||
                             (wh_addr_i == gat_debug_pkg::CAPTURE_ADDR_B));
    if (cap) begin
      m_pend_entry = {(wh_addr_i == gat_debug_pkg::CAPTURE_ADDR_B),
                      m_sm_count[gat_debug_pkg::STAMP_W-1:0],
                      sppe_i[gat_debug_pkg::CAPTURE_LANE]};
    end
    m_pend = cap;

    oor = feat_ena_i && (feat_addr_i >= gat_debug_pkg::FEAT_ADDR_LIMIT);
    hit = {oor, feat_ena_i,
           stage_vld_i[3], stage_rdy_i[3], stage_vld_i[2], stage_rdy_i[2],
           stage_vld_i[1], stage_rdy_i[1], stage_vld_i[0], stage_rdy_i[0]};
    if (clear_i) begin
      m_flags    = hit;
      m_sm_count = 32'(stage_vld_i[1]);
    end else begin
      m_flags    = m_flags | hit;
      m_sm_count = m_sm_count + 32'(stage_vld_i[1]);
    end
  endfunction

  task automatic compare_outputs();
    logic [31:0] exp_status;
    logic        exp_empty;
    exp_status        = '0;
    exp_status[9:0]   = m_flags;
    exp_status[10]    = m_ovf;
    exp_status[14:11] = 4'(m_queue.size());
    exp_empty         = (m_queue.size() == 0);
    assert (debug_1_o === exp_status)
      else report_mismatch("debug_1_o", debug_1_o, exp_status);
    assert (debug_2_o === m_sm_count)
      else report_mismatch("debug_2_o", debug_2_o, m_sm_count);
    assert (debug_3_o === m_word)
      else report_mismatch("debug_3_o", debug_3_o, m_word);
    assert (trace_empty_o === exp_empty)
      else report_mismatch("trace_empty_o", 32'(trace_empty_o), 32'(exp_empty));
  endtask

  task automatic run_cycle(input logic clr, input logic pop, input trig_mode_e mode);
    logic [gat_debug_pkg::NUM_STAGES-1:0]  vld_n;
    logic [gat_debug_pkg::NUM_STAGES-1:0]  rdy_n;
    logic                                  ena_n;
    logic [gat_debug_pkg::FEAT_ADDR_W-1:0] faddr_n;
    logic [gat_debug_pkg::WH_ADDR_W-1:0]   wh_n;
    logic [gat_debug_pkg::SPPE_LANES-1:0][gat_debug_pkg::SPPE_W-1:0] sppe_n;
    @(posedge clk);
    update_model();
    vld_n = sparse_bits();
    rdy_n = sparse_bits();
    ena_n = ($urandom_range(3) == 0);
    if ($urandom_range(1) == 0) begin
      faddr_n = 16'($urandom_range(32'(gat_debug_pkg::FEAT_ADDR_LIMIT) - 1));
    end else begin
      faddr_n = 16'($urandom_range(32'hffff, 32'(gat_debug_pkg::FEAT_ADDR_LIMIT)));
    end
    wh_n = 14'($urandom);
    for (int l = 0; l < gat_debug_pkg::SPPE_LANES; l++) begin
      sppe_n[l] = 12'($urandom);
    end
    case (mode)
      TRIG_OFTEN: begin
        rdy_n[3] = ($urandom_range(3) != 0);
        wh_n     = trigger_biased_addr();
      end
      TRIG_NONE: begin
        rdy_n[3] = 1'b0;
      end
      TRIG_ALWAYS: begin
        rdy_n[3] = 1'b1;
        wh_n     = ($urandom_range(1) == 0) ? gat_debug_pkg::CAPTURE_ADDR_A
                                            : gat_debug_pkg::CAPTURE_ADDR_B;
      end
      default: begin
      end
    endcase
    stage_vld_i <= vld_n;
    stage_rdy_i <= rdy_n;
    feat_ena_i  <= ena_n;
    feat_addr_i <= faddr_n;
    wh_addr_i   <= wh_n;
    sppe_i      <= sppe_n;
    clear_i     <= clr;
    pop_i       <= pop;
    @(negedge clk);
    compare_outputs();
  endtask

  // pop with no new captures until the queue and any pending push are gone
  // count is the total drop of the DUT fill count seen along the way
  task automatic drain_queue(output int count);
    int unsigned                           guard;
    logic [gat_debug_pkg::TRACE_CNT_W-1:0] fill_before;
    guard = 0;
    count = 0;
    while ((trace_empty_o !== 1'b1) || m_pend || m_pop_q) begin
      if (guard >= drain_timeout) begin
        stop_with_failure("trace queue did not drain before the timeout");
      end else begin
        fill_before = debug_1_o[14:11];
        run_cycle(1'b0, 1'b1, TRIG_NONE);
        if (debug_1_o[14:11] < fill_before) begin
          count = count + int'(fill_before - debug_1_o[14:11]);
        end
        guard++;
      end
    end
  endtask

  initial begin
    void'($urandom(32'h5a28));
    stage_vld_i  = '0;
    stage_rdy_i  = '0;
    feat_ena_i   = 1'b0;
    feat_addr_i  = '0;
    wh_addr_i    = '0;
    sppe_i       = '0;
    clear_i      = 1'b0;
    pop_i        = 1'b0;
    m_flags      = '0;
    m_sm_count   = '0;
    m_ovf        = 1'b0;
    m_pend       = 1'b0;
    m_pend_entry = '0;
    m_pop_q      = 1'b0;
    m_word       = '0;
    rst_n        = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (debug_1_o === 32'd0) else report_mismatch("debug_1_o", debug_1_o, 32'd0);
    assert (debug_2_o === 32'd0) else report_mismatch("debug_2_o", debug_2_o, 32'd0);
    assert (debug_3_o === 32'd0) else report_mismatch("debug_3_o", debug_3_o, 32'd0);
    assert (trace_empty_o === 1'b1)
      else report_mismatch("trace_empty_o", 32'(trace_empty_o), 32'd1);

    // sticky flags, softmax count and clears with strobes in the same cycle
    repeat (200) run_cycle(($urandom_range(31) == 0), 1'b0, TRIG_RANDOM);
    run_cycle(1'b1, 1'b0, TRIG_RANDOM);
    repeat (20) run_cycle(1'b0, 1'b0, TRIG_RANDOM);
    drain_queue(pops);

    // bursts short enough that the queue never overflows
    repeat (6) begin
      repeat (8) run_cycle(($urandom_range(15) == 0), 1'b0, TRIG_OFTEN);
      drain_queue(pops);
    end
    assert (debug_1_o[10] === 1'b0)
      else report_mismatch("debug_1_o[10]", 32'(debug_1_o[10]), 32'd0);

    // twelve captures into an empty queue overflow it
    repeat (12) run_cycle(1'b0, 1'b0, TRIG_ALWAYS);
    repeat (3) run_cycle(1'b0, 1'b0, TRIG_NONE);
    assert (debug_1_o[10] === 1'b1)
      else report_mismatch("debug_1_o[10]", 32'(debug_1_o[10]), 32'd1);
    assert (debug_1_o[14:11] === 4'd8)
      else report_mismatch("debug_1_o[14:11]", 32'(debug_1_o[14:11]), 32'd8);
    drain_queue(pops);
    assert (pops == gat_debug_pkg::TRACE_DEPTH)
      else report_mismatch("popped entries", 32'(pops), 32'(gat_debug_pkg::TRACE_DEPTH));

    // pop requests on an empty queue
    held_word = debug_3_o;
    repeat (4) run_cycle(1'b0, 1'b1, TRIG_NONE);
    assert (debug_3_o === held_word)
      else report_mismatch("debug_3_o", debug_3_o, held_word);
    assert (debug_1_o[14:11] === 4'd0)
      else report_mismatch("debug_1_o[14:11]", 32'(debug_1_o[14:11]), 32'd0);

    // captures mixed with host pops
    repeat (150) run_cycle(($urandom_range(31) == 0), ($urandom_range(1) == 0), TRIG_OFTEN);
    drain_queue(pops);

    $display("Regression passed");
    $finish;
  end

endmodule
